// ==== include/floor_logic_defines.svh ====
`ifndef FLOOR_LOGIC_DEFINES_SVH
`define FLOOR_LOGIC_DEFINES_SVH

// Building served by the car
`define NUM_FLOORS 11

// Enough bits to index every floor
`define FLOOR_W 4

// One slot per floor, so the queue cannot overflow
`define QUEUE_DEPTH 11

`endif

// ==== logic/floor_logic_pkg.sv ====
`include "floor_logic_defines.svh"

package floor_logic_pkg;

    ////////////////////////////////////////
    // Basic floor types
    ////////////////////////////////////////

    typedef logic [`FLOOR_W-1:0] floor_t;

    // One bit per floor, used for buttons and lights alike
    typedef logic [`NUM_FLOORS-1:0] button_vec_t;

    // Which button group produced a request
    typedef enum logic {
        PANEL = 1'b0,
        CALL  = 1'b1
    } request_source_e;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        TRAVEL  = 2'd1,
        RELEASE = 2'd2
    } dispatch_state_e;

    ////////////////////////////////////////
    // Bundles between the blocks
    ////////////////////////////////////////

    // Position report from the car
    typedef struct packed {
        floor_t floor;
        logic   stopped;
    } car_status_t;

    typedef struct packed {
        logic            valid;
        floor_t          floor;
        request_source_e source;
    } request_t;

    // Command towards the car
    typedef struct packed {
        logic   activate;
        logic   direction_up;
        floor_t target_floor;
    } dispatch_cmd_t;

    typedef struct packed {
        logic open_allowed;
        logic close_allowed;
    } door_permit_t;

endpackage

// ==== logic/request_latch.sv ====
`timescale 1ns/1ps
`include "floor_logic_defines.svh"

module request_latch (
    input  logic                          clock,
    input  logic                          reset_n,
    input  floor_logic_pkg::button_vec_t  panel_buttons,
    input  floor_logic_pkg::button_vec_t  call_buttons,
    input  floor_logic_pkg::car_status_t  car,
    input  logic                          flush,
    input  floor_logic_pkg::request_t     served,
    output floor_logic_pkg::button_vec_t  panel_lights,
    output floor_logic_pkg::button_vec_t  call_lights,
    output floor_logic_pkg::request_t     new_request
);
    import floor_logic_pkg::*;

    button_vec_t     car_mask;
    button_vec_t     panel_ok;
    button_vec_t     call_ok;
    logic            pick_valid;
    floor_t          pick_floor;
    request_source_e pick_source;
    logic            already_lit;
    button_vec_t     panel_next;
    button_vec_t     call_next;

    ////////////////////////////////////////
    // Acceptance scan
    ////////////////////////////////////////

    // Presses at the floor where the car stands are ignored
    assign car_mask = button_vec_t'(1) << car.floor;

    assign panel_ok = flush ? '0 : (panel_buttons & ~panel_lights & ~car_mask);
    assign call_ok  = flush ? '0 : (call_buttons & ~call_lights & ~car_mask);

    // Scan downwards so the lowest index wins, panel group last so it overrides call
    always_comb begin
        pick_valid  = 1'b0;
        pick_floor  = '0;
        pick_source = PANEL;
        for (int i = `NUM_FLOORS - 1; i >= 0; i--) begin
            if (call_ok[i]) begin
                pick_valid  = 1'b1;
                pick_floor  = floor_t'(i);
                pick_source = CALL;
            end
        end
        for (int i = `NUM_FLOORS - 1; i >= 0; i--) begin
            if (panel_ok[i]) begin
                pick_valid  = 1'b1;
                pick_floor  = floor_t'(i);
                pick_source = PANEL;
            end
        end
    end

    // A floor already lit in either group is already queued
    assign already_lit = panel_lights[pick_floor] | call_lights[pick_floor];

    always_comb begin
        new_request.valid  = pick_valid && !already_lit;
        new_request.floor  = pick_floor;
        new_request.source = pick_source;
    end

    ////////////////////////////////////////
    // Light registers
    ////////////////////////////////////////

    always_comb begin
        panel_next = panel_lights;
        call_next  = call_lights;
        // Served floor goes dark in both groups
        if (served.valid) begin
            panel_next[served.floor] = 1'b0;
            call_next[served.floor]  = 1'b0;
        end
        if (pick_valid) begin
            if (pick_source == PANEL) begin
                panel_next[pick_floor] = 1'b1;
            end else begin
                call_next[pick_floor] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            panel_lights <= '0;
            call_lights  <= '0;
        end else if (flush) begin
            panel_lights <= '0;
            call_lights  <= '0;
        end else begin
            panel_lights <= panel_next;
            call_lights  <= call_next;
        end
    end

endmodule

// ==== logic/request_queue.sv ====
`timescale 1ns/1ps
`include "floor_logic_defines.svh"

module request_queue #(
    parameter int depth = `QUEUE_DEPTH
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  floor_logic_pkg::request_t  new_request,
    input  floor_logic_pkg::request_t  served,
    input  logic                       flush,
    output floor_logic_pkg::request_t  head
);
    import floor_logic_pkg::*;

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    floor_t          entry_floor [depth];
    request_source_e entry_source [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    // Circular increment
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push = new_request.valid;
    assign pop  = served.valid && (count != '0);

    ////////////////////////////////////////
    // Entry storage
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (push) begin
            entry_floor[wr_ptr]  <= new_request.floor;
            entry_source[wr_ptr] <= new_request.source;
        end
    end

    ////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leaves the count unchanged
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Oldest pending floor
    always_comb begin
        head.valid  = (count != '0);
        head.floor  = entry_floor[rd_ptr];
        head.source = entry_source[rd_ptr];
    end

endmodule

// ==== logic/dispatch_control.sv ====
`timescale 1ns/1ps

module dispatch_control (
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic                            power_switch,
    input  logic                            emergency_btn,
    input  logic                            door_open_btn,
    input  logic                            door_close_btn,
    input  floor_logic_pkg::car_status_t    car,
    input  floor_logic_pkg::request_t       head,
    output logic                            flush,
    output floor_logic_pkg::request_t       served,
    output floor_logic_pkg::dispatch_cmd_t  command,
    output floor_logic_pkg::door_permit_t   doors
);
    import floor_logic_pkg::*;

    dispatch_state_e state;
    dispatch_state_e state_next;
    logic            dispatch;
    logic            arrived;
    logic            car_idle;

    // Power loss or emergency drops every request
    assign flush = !power_switch || emergency_btn;

    ////////////////////////////////////////
    // Dispatch and arrival
    ////////////////////////////////////////

    // Only a standing car takes a new target
    assign dispatch = (state == IDLE) && head.valid && car.stopped;

    // End of travel is the car standing at the target
    assign arrived = (state == TRAVEL) && car.stopped &&
                     (car.floor == command.target_floor);

    always_comb begin
        state_next = state;
        if (flush) begin
            state_next = IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (dispatch) begin
                        state_next = TRAVEL;
                    end
                end
                TRAVEL: begin
                    if (arrived) begin
                        state_next = RELEASE;
                    end
                end
                RELEASE: begin
                    state_next = IDLE;
                end
                default: begin
                    state_next = IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Target and direction are frozen for the whole trip
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            command <= '0;
        end else if (flush) begin
            command.activate <= 1'b0;
        end else if (dispatch) begin
            command.activate     <= 1'b1;
            command.direction_up <= (head.floor > car.floor);
            command.target_floor <= head.floor;
        end else if (arrived) begin
            command.activate <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Served floor and doors
    ////////////////////////////////////////

    // One-cycle pulse that pops the head and clears its lights
    always_comb begin
        served.valid  = (state == RELEASE);
        served.floor  = head.floor;
        served.source = head.source;
    end

    assign car_idle = !flush && car.stopped && !command.activate;

    always_comb begin
        doors.open_allowed  = door_open_btn && car_idle;
        doors.close_allowed = door_close_btn && car_idle;
    end

endmodule

// ==== logic/floor_logic_top.sv ====
`timescale 1ns/1ps

module floor_logic_top (
    input  logic                            clock,
    input  logic                            reset_n,
    input  floor_logic_pkg::button_vec_t    panel_buttons,
    input  floor_logic_pkg::button_vec_t    call_buttons,
    input  logic                            door_open_btn,
    input  logic                            door_close_btn,
    input  logic                            emergency_btn,
    input  logic                            power_switch,
    input  floor_logic_pkg::car_status_t    car,
    output floor_logic_pkg::button_vec_t    panel_lights,
    output floor_logic_pkg::button_vec_t    call_lights,
    output floor_logic_pkg::dispatch_cmd_t  command,
    output floor_logic_pkg::door_permit_t   doors
);
    import floor_logic_pkg::*;

    logic     flush;
    request_t served;
    request_t new_request;
    request_t head;

    // Buttons to lights and new floors
    request_latch u_request_latch (
        .clock         (clock),
        .reset_n       (reset_n),
        .panel_buttons (panel_buttons),
        .call_buttons  (call_buttons),
        .car           (car),
        .flush         (flush),
        .served        (served),
        .panel_lights  (panel_lights),
        .call_lights   (call_lights),
        .new_request   (new_request)
    );

    // Pending floors in arrival order
    request_queue u_request_queue (
        .clock       (clock),
        .reset_n     (reset_n),
        .new_request (new_request),
        .served      (served),
        .flush       (flush),
        .head        (head)
    );

    dispatch_control u_dispatch_control (
        .clock          (clock),
        .reset_n        (reset_n),
        .power_switch   (power_switch),
        .emergency_btn  (emergency_btn),
        .door_open_btn  (door_open_btn),
        .door_close_btn (door_close_btn),
        .car            (car),
        .head           (head),
        .flush          (flush),
        .served         (served),
        .command        (command),
        .doors          (doors)
    );

endmodule

// ==== test/floor_logic_checker.sv ====
`timescale 1ns/1ps
`include "floor_logic_defines.svh"

module floor_logic_checker (
    input  logic                            clock,
    input  logic                            reset_n,
    input  floor_logic_pkg::button_vec_t    panel_buttons,
    input  floor_logic_pkg::button_vec_t    call_buttons,
    input  logic                            door_open_btn,
    input  logic                            door_close_btn,
    input  logic                            emergency_btn,
    input  logic                            power_switch,
    input  floor_logic_pkg::car_status_t    car,
    input  floor_logic_pkg::button_vec_t    panel_lights,
    input  floor_logic_pkg::button_vec_t    call_lights,
    input  floor_logic_pkg::dispatch_cmd_t  command,
    input  floor_logic_pkg::door_permit_t   doors
);
    import floor_logic_pkg::*;

    // Expected register values before the coming edge
    button_vec_t     exp_panel;
    button_vec_t     exp_call;
    dispatch_cmd_t   exp_cmd;
    dispatch_state_e exp_state;
    int              pending [$];

    string test_name    = "none";
    int    test_checks  = 0;
    int    test_errors  = 0;
    int    tests_run    = 0;
    int    total_checks = 0;
    int    total_errors = 0;

    ////////////////////////////////////////
    // Test bookkeeping
    ////////////////////////////////////////

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("TEST %s passed, %0d checks", test_name, test_checks);
        end else begin
            $display("TEST %s failed, %0d of %0d checks wrong", test_name, test_errors,
                     test_checks);
        end
    endtask

    task automatic report_totals();
        $display("Totals: %0d tests, %0d checks, %0d errors", tests_run, total_checks,
                 total_errors);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        test_checks++;
        total_checks++;
        if (expected !== actual) begin
            test_errors++;
            total_errors++;
            $display("MISMATCH %s %s: expected %0h, actual %0h", test_name, what,
                     expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    task automatic compare_ports();
        door_permit_t exp_doors;
        logic         car_idle;
        car_idle = power_switch && !emergency_btn && car.stopped && !exp_cmd.activate;
        exp_doors.open_allowed  = door_open_btn && car_idle;
        exp_doors.close_allowed = door_close_btn && car_idle;
        check_value("panel_lights", exp_panel, panel_lights);
        check_value("call_lights", exp_call, call_lights);
        check_value("command", exp_cmd, command);
        check_value("doors", exp_doors, doors);
    endtask

    task automatic step_model();
        logic found;
        logic pick_panel;
        logic was_lit;
        logic serve;
        int   pick;
        int   served_floor;
        found      = 1'b0;
        pick_panel = 1'b1;
        pick       = 0;
        if (!power_switch || emergency_btn) begin
            exp_panel = '0;
            exp_call  = '0;
            exp_state = IDLE;
            exp_cmd.activate = 1'b0;
            pending.delete();
        end else begin
            // Lowest panel floor first, then lowest call floor
            for (int i = 0; i < `NUM_FLOORS; i++) begin
                if (!found && panel_buttons[i] && !exp_panel[i] && i != int'(car.floor)) begin
                    found = 1'b1;
                    pick  = i;
                end
            end
            for (int i = 0; i < `NUM_FLOORS; i++) begin
                if (!found && call_buttons[i] && !exp_call[i] && i != int'(car.floor)) begin
                    found      = 1'b1;
                    pick       = i;
                    pick_panel = 1'b0;
                end
            end
            was_lit      = found && (exp_panel[pick] || exp_call[pick]);
            serve        = (exp_state == RELEASE);
            served_floor = (pending.size() > 0) ? pending[0] : 0;
            if (serve) begin
                exp_panel[served_floor] = 1'b0;
                exp_call[served_floor]  = 1'b0;
            end
            if (found && pick_panel) begin
                exp_panel[pick] = 1'b1;
            end else if (found) begin
                exp_call[pick] = 1'b1;
            end
            case (exp_state)
                IDLE: begin
                    if (pending.size() > 0 && car.stopped) begin
                        exp_state            = TRAVEL;
                        exp_cmd.activate     = 1'b1;
                        exp_cmd.target_floor = floor_t'(pending[0]);
                        exp_cmd.direction_up = pending[0] > int'(car.floor);
                    end
                end
                TRAVEL: begin
                    if (car.stopped && car.floor == exp_cmd.target_floor) begin
                        exp_state        = RELEASE;
                        exp_cmd.activate = 1'b0;
                    end
                end
                default: begin
                    exp_state = IDLE;
                end
            endcase
            if (serve && pending.size() > 0) begin
                void'(pending.pop_front());
            end
            if (found && !was_lit) begin
                pending.push_back(pick);
            end
        end
    endtask

    // DUT registers update by nonblocking assignment, so their old values are seen here
    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            exp_panel = '0;
            exp_call  = '0;
            exp_cmd   = '0;
            exp_state = IDLE;
            pending.delete();
        end else begin
            compare_ports();
            step_model();
        end
    end

endmodule

// ==== test/tb_floor_logic.sv ====
`timescale 1ns/1ps
`include "floor_logic_defines.svh"

module tb_floor_logic;
    import floor_logic_pkg::*;

    localparam int accept_presses = 24;
    localparam int fifo_presses   = 30;
    localparam int door_presses   = 20;
    localparam int flush_before   = 12;
    localparam int flush_after    = 6;
    localparam int total_presses  = accept_presses + fifo_presses + door_presses +
                                    2 * (flush_before + flush_after);
    localparam int cycle_limit    = total_presses * 20 + 200;

    logic          clock;
    logic          reset_n;
    button_vec_t   panel_buttons;
    button_vec_t   call_buttons;
    logic          door_open_btn;
    logic          door_close_btn;
    logic          emergency_btn;
    logic          power_switch;
    car_status_t   car;
    button_vec_t   panel_lights;
    button_vec_t   call_lights;
    dispatch_cmd_t command;
    door_permit_t  doors;

    integer seed = 91748;
    int     cycle_count;
    logic   door_noise;

    floor_logic_top u_floor_logic_top (
        .clock          (clock),
        .reset_n        (reset_n),
        .panel_buttons  (panel_buttons),
        .call_buttons   (call_buttons),
        .door_open_btn  (door_open_btn),
        .door_close_btn (door_close_btn),
        .emergency_btn  (emergency_btn),
        .power_switch   (power_switch),
        .car            (car),
        .panel_lights   (panel_lights),
        .call_lights    (call_lights),
        .command        (command),
        .doors          (doors)
    );

    floor_logic_checker u_checker (
        .clock          (clock),
        .reset_n        (reset_n),
        .panel_buttons  (panel_buttons),
        .call_buttons   (call_buttons),
        .door_open_btn  (door_open_btn),
        .door_close_btn (door_close_btn),
        .emergency_btn  (emergency_btn),
        .power_switch   (power_switch),
        .car            (car),
        .panel_lights   (panel_lights),
        .call_lights    (call_lights),
        .command        (command),
        .doors          (doors)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic int rand_range(input int lo, input int hi);
        int unsigned r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    ////////////////////////////////////////
    // Car and door models
    ////////////////////////////////////////

    // Car leaves on activate and turns up at the target after a random trip
    initial begin
        int trip;
        car.floor   = '0;
        car.stopped = 1'b1;
        forever begin
            @(negedge clock);
            if (reset_n && command.activate && car.stopped) begin
                car.stopped = 1'b0;
                trip = rand_range(3, 12);
                repeat (trip) @(negedge clock);
                car.floor   = command.target_floor;
                car.stopped = 1'b1;
            end
        end
    end

    always @(negedge clock) begin
        if (door_noise) begin
            door_open_btn  = (rand_range(0, 1) == 1);
            door_close_btn = (rand_range(0, 1) == 1);
        end else begin
            door_open_btn  = 1'b0;
            door_close_btn = 1'b0;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////

    // One-cycle press of a single button or of several when multi is set
    task automatic press(input logic multi);
        int gap;
        @(negedge clock);
        if (multi) begin
            panel_buttons = button_vec_t'($random(seed)) & button_vec_t'($random(seed));
            call_buttons  = button_vec_t'($random(seed)) & button_vec_t'($random(seed));
        end else if (rand_range(0, 1) == 0) begin
            panel_buttons = button_vec_t'(1) << rand_range(0, `NUM_FLOORS - 1);
        end else begin
            call_buttons = button_vec_t'(1) << rand_range(0, `NUM_FLOORS - 1);
        end
        @(negedge clock);
        panel_buttons = '0;
        call_buttons  = '0;
        gap = rand_range(0, 3);
        repeat (gap) @(negedge clock);
    endtask

    task automatic hold_flush(input logic by_emergency);
        int hold;
        hold = rand_range(2, 5);
        @(negedge clock);
        if (by_emergency) begin
            emergency_btn = 1'b1;
        end else begin
            power_switch = 1'b0;
        end
        repeat (hold) @(negedge clock);
        emergency_btn = 1'b0;
        power_switch  = 1'b1;
    endtask

    // All lights dark and the car released
    task automatic wait_drained();
        @(negedge clock);
        while (panel_lights != '0 || call_lights != '0 || command.activate) begin
            @(negedge clock);
        end
        repeat (2) @(negedge clock);
    endtask

    // Door buttons stay busy so the permits are also seen while flushed
    task automatic run_flush_test(input string name, input logic by_emergency);
        u_checker.start_test(name);
        door_noise = 1'b1;
        repeat (flush_before) press(1'b0);
        hold_flush(by_emergency);
        repeat (flush_after) press(1'b0);
        wait_drained();
        door_noise = 1'b0;
        u_checker.finish_test();
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        panel_buttons  = '0;
        call_buttons   = '0;
        door_open_btn  = 1'b0;
        door_close_btn = 1'b0;
        emergency_btn  = 1'b0;
        power_switch   = 1'b1;
        door_noise     = 1'b0;
        reset_n        = 1'b0;

        u_checker.start_test("reset_state");
        repeat (5) @(negedge clock);
        reset_n = 1'b1;
        repeat (4) @(negedge clock);
        u_checker.finish_test();

        u_checker.start_test("accept_priority");
        repeat (accept_presses) press(1'b1);
        wait_drained();
        u_checker.finish_test();

        u_checker.start_test("fifo_dispatch");
        repeat (fifo_presses) press(1'b0);
        wait_drained();
        u_checker.finish_test();

        u_checker.start_test("door_permits");
        door_noise = 1'b1;
        repeat (door_presses) press(1'b0);
        wait_drained();
        door_noise = 1'b0;
        u_checker.finish_test();

        run_flush_test("power_off_flush", 1'b0);
        run_flush_test("emergency_flush", 1'b1);

        u_checker.report_totals();
        if (u_checker.total_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
logic/floor_logic_pkg.sv
logic/request_latch.sv
logic/request_queue.sv
logic/dispatch_control.sv
logic/floor_logic_top.sv
test/floor_logic_checker.sv
test/tb_floor_logic.sv

// ==== Bender.yml ====
package:
  name: floor_logic

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/floor_logic_pkg.sv
      - logic/request_latch.sv
      - logic/request_queue.sv
      - logic/dispatch_control.sv
      - logic/floor_logic_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/floor_logic_checker.sv
      - test/tb_floor_logic.sv
